/* Makefile */
SRCS := $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_ps2_mouse

obj_dir/Vtb_ps2_mouse: files.f $(SRCS)
	verilator --binary --timing --assert -f files.f --top-module tb_ps2_mouse -o Vtb_ps2_mouse

run: obj_dir/Vtb_ps2_mouse
	@out="$$(./obj_dir/Vtb_ps2_mouse)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

/* files.f */
+incdir+verilog
verilog/ps2_pkg.sv
verilog/mouse_pkg.sv
verilog/ps2_line_io.sv
verilog/ps2_rx_frame.sv
verilog/ps2_tx_frame.sv
verilog/mouse_packet_asm.sv
verilog/sync_fifo.sv
verilog/mouse_regs.sv
verilog/ps2_mouse_top.sv
tb/ps2_device_model.sv
tb/tb_ps2_mouse.sv

/* tb/ps2_device_model.sv */
`timescale 1ns/1ps

module ps2_device_model import ps2_pkg::*; (
  inout  wire       ps2_clk,
  inout  wire       ps2_data,
  input  ps2_byte_t send_byte,
  input  logic      send_bad_par,
  input  int        send_req,
  output int        send_count,
  output int        cmd_count,
  output int        ack_count,
  output ps2_byte_t cmd_byte,
  output logic      cmd_ok
);

  localparam int half_bit    = 20000;  // 40 us device clock
  localparam int quarter_bit = 10000;
  localparam int frame_gap   = 50000;

  logic clk_low;
  logic data_low;

  assign ps2_clk  = clk_low ? 1'b0 : 1'bz;
  assign ps2_data = data_low ? 1'b0 : 1'bz;

  // start, 8 data lsb first, odd parity, stop
  task automatic send_frame(input ps2_byte_t b, input logic bad_par);
    logic [10:0] bits;
    int          i;
    bits = {1'b1, (~^b) ^ bad_par, b, 1'b0};
    #frame_gap;
    for (i = 0; i < 11; i++) begin
      data_low = !bits[i];
      #quarter_bit;
      clk_low = 1'b1;
      #half_bit;
      clk_low = 1'b0;
      #quarter_bit;
    end
    data_low = 1'b0;
  endtask

  // host request to send, sampled on rising clock
  task automatic receive_cmd();
    logic [9:0] bits;
    logic       start_ok;
    int         i;
    wait (ps2_clk === 1'b1);  // inhibit over
    #quarter_bit;
    start_ok = (ps2_data === 1'b0);
    for (i = 0; i < 10; i++) begin
      clk_low = 1'b1;
      #half_bit;
      clk_low = 1'b0;
      #quarter_bit;
      bits[i] = ps2_data;
      #quarter_bit;
    end
    data_low = 1'b1;  // ack bit
    clk_low  = 1'b1;
    #half_bit;
    clk_low = 1'b0;
    #quarter_bit;
    data_low  = 1'b0;
    cmd_byte  = bits[7:0];
    cmd_ok    = start_ok && (^bits[8:0]) && bits[9];
    cmd_count = cmd_count + 1;
  endtask

  initial begin
    clk_low    = 1'b0;
    data_low   = 1'b0;
    send_count = 0;
    cmd_count  = 0;
    ack_count  = 0;
    cmd_byte   = '0;
    cmd_ok     = 1'b0;
    forever begin
      #1000;
      if (ps2_clk === 1'b0) begin  // host inhibit
        receive_cmd();
        send_frame(8'hfa, 1'b0);
        ack_count = ack_count + 1;
      end else if (send_req != send_count) begin
        send_frame(send_byte, send_bad_par);
        send_count = send_count + 1;
      end
    end
  end

endmodule

/* tb/tb_ps2_mouse.sv */
`timescale 1ns/1ps
`include "mouse_cfg.svh"

module tb_ps2_mouse import ps2_pkg::*, mouse_pkg::*;;

  localparam int bit_cycles  = 2000;  // one device bit at 50 MHz
  localparam int frame_count = 32;
  localparam int cycle_limit =
    (frame_count * 12 * bit_cycles + 8 * `MOUSE_INHIBIT_CYCLES) * 3 / 2;

  logic          MOUSE_CLOCK;
  logic          mouse_reset_n;
  logic          io_cs;
  logic          wr;
  mouse_addr_e   addr;
  ps2_byte_t     wdata;
  logic [31:0]   rdata;
  logic          irq;
  wire           ps2_clk;
  wire           ps2_data;

  ps2_byte_t     dev_byte;
  logic          dev_bad_par;
  int            dev_req;
  int            dev_sent;
  int            cmd_cnt;
  int            ack_cnt;
  ps2_byte_t     cmd_byte;
  logic          cmd_ok;

  int            seed = 18;
  int            errors = 0;
  int            prop_errors = 0;
  int            checks = 0;
  int            tests = 0;
  int            failed_tests = 0;
  int            cycles = 0;
  mouse_packet_t exp_q[$];

  pullup (ps2_clk);
  pullup (ps2_data);

  ps2_mouse_top ps2_mouse_top_i (.MOUSE_CLOCK, .mouse_reset_n, .ps2_clk, .ps2_data,
                                 .io_cs, .addr, .wr, .wdata, .rdata, .irq);

  ps2_device_model device_i (.ps2_clk, .ps2_data, .send_byte(dev_byte),
                             .send_bad_par(dev_bad_par), .send_req(dev_req),
                             .send_count(dev_sent), .cmd_count(cmd_cnt),
                             .ack_count(ack_cnt), .cmd_byte, .cmd_ok);

  initial begin
    MOUSE_CLOCK = 1'b0;
    forever #10 MOUSE_CLOCK = ~MOUSE_CLOCK;
  end

  initial begin
    while (cycles < cycle_limit) begin
      @(posedge MOUSE_CLOCK);
      cycles++;
    end
    $display("timeout after %0d cycles, the device or the host stalled", cycles);
    $display("Checks failed");
    $finish;
  end

  // irq drops only after a packet read
  assert property (@(posedge MOUSE_CLOCK) disable iff (!mouse_reset_n)
                   $fell(irq) |-> $past(io_cs && !wr && addr == addr_packet))
    else begin
      prop_errors++;
      $display("irq fell without a packet read");
    end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act == exp) else begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int start_errs);
    tests++;
    if (errors == start_errs) $display("test %s: ok", name);
    else begin
      failed_tests++;
      $display("test %s: failed with %0d errors", name, errors - start_errs);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus and device helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic bus_write(input mouse_addr_e a, input ps2_byte_t d);
    @(posedge MOUSE_CLOCK);
    #2;
    io_cs = 1'b1;
    wr    = 1'b1;
    addr  = a;
    wdata = d;
    @(posedge MOUSE_CLOCK);
    #2;
    io_cs = 1'b0;
    wr    = 1'b0;
  endtask

  task automatic bus_read(input mouse_addr_e a, output logic [31:0] d);
    @(posedge MOUSE_CLOCK);
    #2;
    io_cs = 1'b1;
    wr    = 1'b0;
    addr  = a;
    @(posedge MOUSE_CLOCK);
    #2;
    io_cs = 1'b0;
    d     = rdata;  // registered at that edge
  endtask

  task automatic device_send(input ps2_byte_t b, input logic bad_par);
    dev_byte    = b;
    dev_bad_par = bad_par;
    dev_req     = dev_req + 1;
    wait (dev_sent == dev_req);
  endtask

  function automatic ps2_byte_t rand_byte();
    return ps2_byte_t'($random(seed));
  endfunction

  function automatic mouse_packet_t rand_packet();
    ps2_byte_t b0;
    do begin
      b0 = rand_byte() | 8'h08;  // sync bit
    end while (b0 == 8'hfa);  // that first byte is an ack
    return mouse_packet_t'({b0, rand_byte(), rand_byte()});
  endfunction

  task automatic send_packet(input mouse_packet_t p);
    device_send(p[23:16], 1'b0);
    device_send(p[15:8], 1'b0);
    device_send(p[7:0], 1'b0);
  endtask

  task automatic read_packet(input string name, input mouse_packet_t exp);
    logic [31:0] word;
    bus_read(addr_packet, word);
    check(name, 32'(exp), word);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    logic [31:0]   word;
    mouse_status_t st;
    mouse_status_t exp_st;
    mouse_packet_t pkt;
    int            start_errs;
    int            i;

    io_cs         = 1'b0;
    wr            = 1'b0;
    addr          = addr_status;
    wdata         = '0;
    dev_byte      = '0;
    dev_bad_par   = 1'b0;
    dev_req       = 0;
    mouse_reset_n = 1'b0;
    repeat (4) @(posedge MOUSE_CLOCK);
    #2 mouse_reset_n = 1'b1;

    start_errs = errors;
    wait (ack_cnt == 1);  // 0xf4 taken and answered
    check("init command byte", 32'(`MOUSE_INIT_CMD), 32'(cmd_byte));
    check("init frame bits", 32'(1'b1), 32'(cmd_ok));
    bus_read(addr_status, word);
    exp_st = '0;
    exp_st.ack_seen = 1'b1;
    check("status after init", 32'(exp_st), word);
    report_test("init_command", start_errs);

    start_errs = errors;
    pkt = rand_packet();
    send_packet(pkt);
    check("irq with packet", 32'(1'b1), 32'(irq));
    read_packet("random packet", pkt);
    check("irq after read", 32'(1'b0), 32'(irq));
    report_test("single_packet", start_errs);

    start_errs = errors;
    device_send(rand_byte(), 1'b1);
    bus_read(addr_status, word);
    st = mouse_status_t'(word[$bits(mouse_status_t)-1:0]);
    check("parity error bit", 32'(1'b1), 32'(st.perr));
    check("irq after bad byte", 32'(1'b0), 32'(irq));
    pkt = rand_packet();
    send_packet(pkt);
    read_packet("packet after parity error", pkt);
    check("irq after read", 32'(1'b0), 32'(irq));
    report_test("parity_error", start_errs);

    start_errs = errors;
    device_send(rand_byte() & 8'hf7, 1'b0);  // sync bit clear
    check("irq after unsynced byte", 32'(1'b0), 32'(irq));
    pkt = rand_packet();
    send_packet(pkt);
    read_packet("packet after resync", pkt);
    check("irq after read", 32'(1'b0), 32'(irq));
    report_test("resync", start_errs);

    start_errs = errors;
    for (i = 0; i <= `MOUSE_PKT_DEPTH; i++) begin
      pkt = rand_packet();
      exp_q.push_back(pkt);
      send_packet(pkt);
    end
    bus_read(addr_status, word);
    st = mouse_status_t'(word[$bits(mouse_status_t)-1:0]);
    check("overflow bit", 32'(1'b1), 32'(st.overflow));
    for (i = 0; i < `MOUSE_PKT_DEPTH; i++) begin
      read_packet($sformatf("queued packet %0d", i), exp_q[i]);
    end
    check("irq after draining", 32'(1'b0), 32'(irq));
    report_test("overflow", start_errs);

    start_errs = errors;
    check("commands before write", 32'(1), 32'(cmd_cnt));
    bus_write(addr_status, 8'hff);
    bus_read(addr_status, word);
    st = mouse_status_t'(word[$bits(mouse_status_t)-1:0]);
    check("sticky bits cleared", 32'(4'b0000),
          32'({st.tx_error, st.overflow, st.perr, st.ack_seen}));
    wait (ack_cnt == 2);
    check("queued command byte", 32'(8'hff), 32'(cmd_byte));
    check("queued frame bits", 32'(1'b1), 32'(cmd_ok));
    bus_read(addr_status, word);
    check("status after command", 32'(exp_st), word);
    report_test("clear_and_command", start_errs);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors + prop_errors);
    if (errors + prop_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* verilog/mouse_cfg.svh */
`ifndef MOUSE_CFG_SVH
`define MOUSE_CFG_SVH

// host clock-low hold before a send, 100 us at 50 MHz
`define MOUSE_INHIBIT_CYCLES 5000

// queue depths
`define MOUSE_CMD_DEPTH 4
`define MOUSE_PKT_DEPTH 4

// stream enable, sent once after reset
`define MOUSE_INIT_CMD 8'hf4

`endif

/* verilog/mouse_packet_asm.sv */
`timescale 1ns/1ps

module mouse_packet_asm import ps2_pkg::*, mouse_pkg::*; (
  input  logic          MOUSE_CLOCK,
  input  logic          mouse_reset_n,
  input  ps2_rx_t       rx,
  output logic          push,
  output mouse_packet_t packet,
  output logic          ack_seen
);

  logic [1:0] pos;  // byte position in the packet
  ps2_byte_t  byte0;
  ps2_byte_t  byte1;

  always_ff @(posedge MOUSE_CLOCK or negedge mouse_reset_n) begin
    if (!mouse_reset_n) begin
      pos      <= '0;
      push     <= 1'b0;
      ack_seen <= 1'b0;
    end else begin
      push     <= 1'b0;
      ack_seen <= 1'b0;
      if (rx.valid) begin
        if (rx.perr) pos <= '0;  // realign
        else if (pos == 2'd0) begin
          if (rx.data == 8'hfa) ack_seen <= 1'b1;
          else if (rx.data[3]) pos <= 2'd1;  // else resync, drop it
        end else if (pos == 2'd1) pos <= 2'd2;
        else begin
          pos  <= '0;
          push <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge MOUSE_CLOCK) begin
    if (rx.valid && !rx.perr) begin
      if (pos == 2'd0) byte0 <= rx.data;
      if (pos == 2'd1) byte1 <= rx.data;
      if (pos == 2'd2) packet <= mouse_packet_t'({byte0, byte1, rx.data});
    end
  end

endmodule

/* verilog/mouse_pkg.sv */
package mouse_pkg;

  // three-byte movement packet, first byte in the top bits
  typedef struct packed {
    logic       y_ovf;
    logic       x_ovf;
    logic       y_sign;
    logic       x_sign;
    logic       sync;    // always one in a good first byte
    logic       btn_m;
    logic       btn_r;
    logic       btn_l;
    logic [7:0] dx;
    logic [7:0] dy;
  } mouse_packet_t;

  // status word, pkt_avail at bit 0
  typedef struct packed {
    logic tx_error;   // sticky, no device ack
    logic overflow;   // sticky, packet dropped
    logic perr;       // sticky, rx parity
    logic ack_seen;   // sticky, 0xfa received
    logic tx_busy;
    logic cmd_full;
    logic pkt_avail;
  } mouse_status_t;

  typedef enum logic {
    addr_status = 1'b0,  // rd status, wr clear + command
    addr_packet = 1'b1   // rd and pop packet
  } mouse_addr_e;

endpackage

/* verilog/mouse_regs.sv */
`timescale 1ns/1ps

module mouse_regs import ps2_pkg::*, mouse_pkg::*; (
  input  logic          MOUSE_CLOCK,
  input  logic          mouse_reset_n,
  input  logic          io_cs,
  input  logic          wr,
  input  mouse_addr_e   addr,
  input  ps2_byte_t     wdata,
  output logic [31:0]   rdata,
  output logic          irq,
  output logic          cmd_push,
  output ps2_byte_t     cmd_data,
  input  logic          cmd_full,
  input  logic          pkt_empty,
  input  mouse_packet_t pkt_head,
  output logic          pkt_pop,
  input  logic          pkt_drop,
  input  logic          ack_seen,
  input  logic          rx_perr,
  input  logic          tx_busy,
  input  logic          tx_error
);

  mouse_status_t status;
  logic          st_ack;
  logic          st_perr;
  logic          st_ovf;
  logic          st_txerr;
  logic          rd_strobe;
  logic          wr_status;

  assign rd_strobe = io_cs && !wr;
  assign wr_status = io_cs && wr && (addr == addr_status);
  assign pkt_pop   = rd_strobe && (addr == addr_packet) && !pkt_empty;
  assign irq       = !pkt_empty;

  assign status = '{tx_error: st_txerr, overflow: st_ovf, perr: st_perr,
                    ack_seen: st_ack, tx_busy: tx_busy, cmd_full: cmd_full,
                    pkt_avail: !pkt_empty};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sticky bits, a new event in the clearing cycle still lands
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge MOUSE_CLOCK or negedge mouse_reset_n) begin
    if (!mouse_reset_n) begin
      st_ack   <= 1'b0;
      st_perr  <= 1'b0;
      st_ovf   <= 1'b0;
      st_txerr <= 1'b0;
      cmd_push <= 1'b0;
      rdata    <= '0;
    end else begin
      cmd_push <= wr_status && !cmd_full;  // full queue ignores the write
      st_ack   <= (st_ack && !wr_status) || ack_seen;
      st_perr  <= (st_perr && !wr_status) || rx_perr;
      st_ovf   <= (st_ovf && !wr_status) || pkt_drop;
      st_txerr <= (st_txerr && !wr_status) || tx_error;
      if (rd_strobe) begin
        if (addr == addr_status) rdata <= 32'(status);
        else rdata <= pkt_empty ? 32'd0 : 32'(pkt_head);
      end
    end
  end

  always_ff @(posedge MOUSE_CLOCK) begin
    if (wr_status) cmd_data <= wdata;
  end

endmodule

/* verilog/ps2_line_io.sv */
`timescale 1ns/1ps

module ps2_line_io import ps2_pkg::*; (
  input  logic      MOUSE_CLOCK,
  input  logic      mouse_reset_n,
  inout  wire       ps2_clk,
  inout  wire       ps2_data,
  input  logic      clk_low_en,
  input  logic      data_low_en,
  output ps2_line_t line
);

  logic [1:0] clk_sync;
  logic [1:0] data_sync;
  logic       clk_q;
  logic       data_q;
  logic       fall_q;

  // open drain, pulled up outside
  assign ps2_clk  = clk_low_en ? 1'b0 : 1'bz;
  assign ps2_data = data_low_en ? 1'b0 : 1'bz;

  always_ff @(posedge MOUSE_CLOCK or negedge mouse_reset_n) begin
    if (!mouse_reset_n) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_q     <= 1'b1;
      data_q    <= 1'b1;
      fall_q    <= 1'b0;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_q     <= clk_sync[1];
      data_q    <= data_sync[1];  // keeps data in step with fall
      fall_q    <= clk_q && !clk_sync[1];
    end
  end

  assign line = '{clk: clk_q, data: data_q, fall: fall_q};

endmodule

/* verilog/ps2_mouse_top.sv */
`timescale 1ns/1ps
`include "mouse_cfg.svh"

module ps2_mouse_top import ps2_pkg::*, mouse_pkg::*; (
  input  logic        MOUSE_CLOCK,
  input  logic        mouse_reset_n,
  inout  wire         ps2_clk,
  inout  wire         ps2_data,
  input  logic        io_cs,
  input  mouse_addr_e addr,
  input  logic        wr,
  input  ps2_byte_t   wdata,
  output logic [31:0] rdata,
  output logic        irq
);

  ps2_line_t     line;
  ps2_rx_t       rx;
  logic          clk_low_en, data_low_en;
  logic          tx_busy, tx_error;
  logic          cmd_push, cmd_pop, cmd_empty, cmd_full;
  ps2_byte_t     cmd_data, cmd_head;
  logic          pkt_push, pkt_pop, pkt_empty, pkt_full;
  mouse_packet_t pkt_in, pkt_head;
  logic          ack_seen;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // line side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  ps2_line_io line_io_i (.MOUSE_CLOCK, .mouse_reset_n, .ps2_clk, .ps2_data,
                         .clk_low_en, .data_low_en, .line);

  ps2_rx_frame rx_frame_i (.MOUSE_CLOCK, .mouse_reset_n, .line, .hold(tx_busy), .rx);

  ps2_tx_frame tx_frame_i (.MOUSE_CLOCK, .mouse_reset_n, .line, .cmd(cmd_head),
                           .cmd_ready(!cmd_empty), .cmd_pop, .clk_low_en, .data_low_en,
                           .busy(tx_busy), .done(), .error(tx_error));

  mouse_packet_asm packet_asm_i (.MOUSE_CLOCK, .mouse_reset_n, .rx, .push(pkt_push),
                                 .packet(pkt_in), .ack_seen);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // queues and bus side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  sync_fifo #(.item_t(ps2_byte_t), .depth(`MOUSE_CMD_DEPTH)) cmd_fifo_i (
    .MOUSE_CLOCK, .mouse_reset_n, .push(cmd_push), .pop(cmd_pop),
    .wdata(cmd_data), .rdata(cmd_head), .empty(cmd_empty), .full(cmd_full));

  sync_fifo #(.item_t(mouse_packet_t), .depth(`MOUSE_PKT_DEPTH)) pkt_fifo_i (
    .MOUSE_CLOCK, .mouse_reset_n, .push(pkt_push), .pop(pkt_pop),
    .wdata(pkt_in), .rdata(pkt_head), .empty(pkt_empty), .full(pkt_full));

  mouse_regs regs_i (
    .MOUSE_CLOCK, .mouse_reset_n, .io_cs, .wr, .addr, .wdata, .rdata, .irq,
    .cmd_push, .cmd_data, .cmd_full, .pkt_empty, .pkt_head, .pkt_pop,
    .pkt_drop(pkt_push && pkt_full),  // queue full, packet lost
    .ack_seen, .rx_perr(rx.valid && rx.perr), .tx_busy, .tx_error);

endmodule

/* verilog/ps2_pkg.sv */
package ps2_pkg;

  // one frame payload
  typedef logic [7:0] ps2_byte_t;

  // received frame, data valid only with the strobe
  typedef struct packed {
    ps2_byte_t data;
    logic      valid;  // one-cycle strobe
    logic      perr;   // odd parity failed
  } ps2_rx_t;

  // synchronised line state
  typedef struct packed {
    logic clk;   // clock level
    logic data;  // data level, aligned with fall
    logic fall;  // one cycle per falling clock edge
  } ps2_line_t;

endpackage

/* verilog/ps2_rx_frame.sv */
`timescale 1ns/1ps

module ps2_rx_frame import ps2_pkg::*; (
  input  logic      MOUSE_CLOCK,
  input  logic      mouse_reset_n,
  input  ps2_line_t line,
  input  logic      hold,
  output ps2_rx_t   rx
);

  logic [3:0] bit_cnt;  // 0 waits for start, 10 is the stop bit
  ps2_byte_t  shreg;
  logic       par_bit;
  logic       rx_valid;
  logic       rx_perr;

  always_ff @(posedge MOUSE_CLOCK or negedge mouse_reset_n) begin
    if (!mouse_reset_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      rx_perr  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (hold) begin
        bit_cnt <= '0;  // host owns the line
      end else if (line.fall) begin
        case (bit_cnt)
          4'd0: if (!line.data) bit_cnt <= 4'd1;
          4'd10: begin
            bit_cnt <= '0;
            if (line.data) begin  // bad stop drops the frame
              rx_valid <= 1'b1;
              rx_perr  <= ~^{shreg, par_bit};
            end
          end
          default: bit_cnt <= bit_cnt + 4'd1;
        endcase
      end
    end
  end

  // data and parity bits
  always_ff @(posedge MOUSE_CLOCK) begin
    if (!hold && line.fall) begin
      if (bit_cnt == 4'd9) begin
        par_bit <= line.data;
      end else if (bit_cnt != 4'd0 && bit_cnt != 4'd10) begin
        shreg <= {line.data, shreg[7:1]};  // lsb first
      end
    end
  end

  assign rx = '{data: shreg, valid: rx_valid, perr: rx_perr};

endmodule

/* verilog/ps2_tx_frame.sv */
`timescale 1ns/1ps
`include "mouse_cfg.svh"

module ps2_tx_frame import ps2_pkg::*; (
  input  logic      MOUSE_CLOCK,
  input  logic      mouse_reset_n,
  input  ps2_line_t line,
  input  ps2_byte_t cmd,
  input  logic      cmd_ready,
  output logic      cmd_pop,
  output logic      clk_low_en,
  output logic      data_low_en,
  output logic      busy,
  output logic      done,
  output logic      error
);

  localparam int inhibit_cycles = `MOUSE_INHIBIT_CYCLES;
  localparam int hold_w = $clog2(inhibit_cycles);

  typedef enum logic [1:0] {st_idle, st_inhibit, st_send, st_release} tx_state_e;

  tx_state_e         state;
  logic              init_pend;
  logic [hold_w-1:0] hold_cnt;
  logic [3:0]        bit_cnt;
  logic [9:0]        shreg;      // parity, data, start; stop shifts in
  ps2_byte_t         next_byte;

  assign next_byte   = init_pend ? `MOUSE_INIT_CMD : cmd;
  assign cmd_pop     = (state == st_idle) && !init_pend && cmd_ready;
  assign clk_low_en  = (state == st_inhibit);
  assign data_low_en = (state == st_send) && !shreg[0];
  assign busy        = (state != st_idle);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // inhibit, start bit, 8 data, parity, stop, then the device ack
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge MOUSE_CLOCK or negedge mouse_reset_n) begin
    if (!mouse_reset_n) begin
      state     <= st_idle;
      init_pend <= 1'b1;
      hold_cnt  <= '0;
      bit_cnt   <= '0;
      shreg     <= '1;
      done      <= 1'b0;
      error     <= 1'b0;
    end else begin
      done  <= 1'b0;
      error <= 1'b0;
      case (state)
        st_idle: if (init_pend || cmd_ready) begin
          init_pend <= 1'b0;
          shreg     <= {~^next_byte, next_byte, 1'b0};  // odd parity
          hold_cnt  <= hold_w'(inhibit_cycles - 1);
          bit_cnt   <= '0;
          state     <= st_inhibit;
        end
        st_inhibit: begin
          if (hold_cnt == '0) state <= st_send;
          else hold_cnt <= hold_cnt - 1'b1;
        end
        st_send: if (line.fall) begin
          if (bit_cnt == 4'd10) begin  // ack bit
            done  <= !line.data;
            error <= line.data;
            state <= st_release;
          end else begin
            shreg   <= {1'b1, shreg[9:1]};
            bit_cnt <= bit_cnt + 4'd1;
          end
        end
        st_release: if (line.clk && line.data) state <= st_idle;  // device lets go
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* verilog/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  depth  = 4
) (
  input  logic  MOUSE_CLOCK,
  input  logic  mouse_reset_n,
  input  logic  push,
  input  logic  pop,
  input  item_t wdata,
  output item_t rdata,
  output logic  empty,
  output logic  full
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  item_t             mem [depth];
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [ptr_w:0]    count;
  logic              do_push;
  logic              do_pop;

  assign empty   = (count == '0);
  assign full    = (count == (ptr_w + 1)'(depth));
  assign do_push = push && !full;  // full drops the item
  assign do_pop  = pop && !empty;
  assign rdata   = mem[rd_ptr];

  always_ff @(posedge MOUSE_CLOCK or negedge mouse_reset_n) begin
    if (!mouse_reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + (ptr_w + 1)'(do_push) - (ptr_w + 1)'(do_pop);
    end
  end

  always_ff @(posedge MOUSE_CLOCK) begin
    if (do_push) mem[wr_ptr] <= wdata;
  end

endmodule
